// File: common/rv32i_types.sv
`default_nettype none

package rv32i_types;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	typedef enum logic [2:0] {
		add  = 3'b000,
		sll  = 3'b001,
		slt  = 3'b010,
		sltu = 3'b011,
		axor = 3'b100,
		sr   = 3'b101,
		aor  = 3'b110,
		aand = 3'b111
	} arith_funct3_t;

	// same encoding as funct3 so that the decoder can cast it straight over
	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_ops;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} rv32i_instr_t;

	localparam logic alumux1_rs1 = 1'b0;
	localparam logic alumux1_pc  = 1'b1;

	localparam logic [2:0] alumux2_i   = 3'd0;
	localparam logic [2:0] alumux2_u   = 3'd1;
	localparam logic [2:0] alumux2_b   = 3'd2;
	localparam logic [2:0] alumux2_s   = 3'd3;
	localparam logic [2:0] alumux2_rs2 = 3'd4;
	localparam logic [2:0] alumux2_j   = 3'd5;

	localparam logic cmpmux_rs2 = 1'b0;
	localparam logic cmpmux_i   = 1'b1;

	localparam logic [2:0] memwbmux_alu = 3'd0;
	localparam logic [2:0] memwbmux_cmp = 3'd1;
	localparam logic [2:0] memwbmux_u   = 3'd2;
	localparam logic [2:0] memwbmux_mem = 3'd3;
	localparam logic [2:0] memwbmux_pc4 = 3'd4;

	localparam logic [31:0] reset_pc = 32'h0000_0000;

endpackage : rv32i_types

`default_nettype wire

// File: hw/decode/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control
	import rv32i_types::*;
(
	input  wire rv32i_opcode opcode,
	input  wire logic [2:0]  funct3,
	input  wire logic [6:0]  funct7,
	input  wire logic [4:0]  rd_in,
	input  wire logic [4:0]  rs1_in,
	input  wire logic [4:0]  rs2_in,

	output alu_ops           aluop,
	output branch_funct3_t   cmpop,
	output logic             alumux1_sel,
	output logic [2:0]       alumux2_sel,
	output logic             cmpmux_sel,
	output logic [2:0]       memwbmux_sel,
	output logic             load_regfile,
	output logic             mem_read,
	output logic             mem_write,
	output logic             jump,
	output logic             branch,
	output logic [4:0]       rd,
	output logic [4:0]       rs1,
	output logic [4:0]       rs2
);

	arith_funct3_t arith_funct3;

	assign arith_funct3 = arith_funct3_t'(funct3);

	always_comb begin
		// an unknown opcode falls through as a no-op that touches nothing
		aluop        = alu_add;
		cmpop        = branch_funct3_t'(funct3);
		alumux1_sel  = alumux1_rs1;
		alumux2_sel  = alumux2_i;
		cmpmux_sel   = cmpmux_rs2;
		memwbmux_sel = memwbmux_alu;
		load_regfile = 1'b0;
		mem_read     = 1'b0;
		mem_write    = 1'b0;
		jump         = 1'b0;
		branch       = 1'b0;
		rs1          = 5'd0;
		rs2          = 5'd0;

		case (opcode)
			op_lui: begin
				load_regfile = 1'b1;
				memwbmux_sel = memwbmux_u;
				alumux2_sel  = alumux2_u;
			end
			op_auipc: begin
				load_regfile = 1'b1;
				alumux1_sel  = alumux1_pc;
				alumux2_sel  = alumux2_u;
			end
			op_jal: begin
				load_regfile = 1'b1;
				memwbmux_sel = memwbmux_pc4;
				alumux1_sel  = alumux1_pc;
				alumux2_sel  = alumux2_j;
				jump         = 1'b1;
			end
			op_jalr: begin
				load_regfile = 1'b1;
				memwbmux_sel = memwbmux_pc4;
				jump         = 1'b1;
				rs1          = rs1_in;
			end
			op_br: begin
				alumux1_sel = alumux1_pc;
				alumux2_sel = alumux2_b;
				branch      = 1'b1;
				rs1         = rs1_in;
				rs2         = rs2_in;
			end
			op_load: begin
				load_regfile = 1'b1;
				mem_read     = 1'b1;
				memwbmux_sel = memwbmux_mem;
				rs1          = rs1_in;
			end
			op_store: begin
				alumux2_sel = alumux2_s;
				mem_write   = 1'b1;
				rs1         = rs1_in;
				rs2         = rs2_in;
			end
			op_imm: begin
				load_regfile = 1'b1;
				aluop        = alu_ops'(funct3);
				rs1          = rs1_in;
				case (arith_funct3)
					slt: begin
						cmpop        = blt;
						cmpmux_sel   = cmpmux_i;
						memwbmux_sel = memwbmux_cmp;
					end
					sltu: begin
						cmpop        = bltu;
						cmpmux_sel   = cmpmux_i;
						memwbmux_sel = memwbmux_cmp;
					end
					sr: aluop = funct7[5] ? alu_sra : alu_srl;
					default: ;
				endcase
			end
			op_reg: begin
				load_regfile = 1'b1;
				alumux2_sel  = alumux2_rs2;
				aluop        = alu_ops'(funct3);
				rs1          = rs1_in;
				rs2          = rs2_in;
				case (arith_funct3)
					add: aluop = funct7[5] ? alu_sub : alu_add;
					slt: begin
						cmpop        = blt;
						memwbmux_sel = memwbmux_cmp;
					end
					sltu: begin
						cmpop        = bltu;
						memwbmux_sel = memwbmux_cmp;
					end
					sr: aluop = funct7[5] ? alu_sra : alu_srl;
					default: ;
				endcase
			end
			default: ;
		endcase

		// stores and branches carry immediate bits in the rd field
		rd = load_regfile ? rd_in : 5'd0;
	end

endmodule : cpu_control

`default_nettype wire

// File: hw/decode/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen
	import rv32i_types::*;
(
	input  wire rv32i_instr_t instr,

	output logic [31:0] i_imm,
	output logic [31:0] s_imm,
	output logic [31:0] b_imm,
	output logic [31:0] u_imm,
	output logic [31:0] j_imm
);

	assign i_imm = {{20{instr.i.imm[11]}}, instr.i.imm};

	assign s_imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};

	// branch and jump offsets are in halfwords, so bit 0 is always zero
	assign b_imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
			instr.b.imm10_5, instr.b.imm4_1, 1'b0};

	assign u_imm = {instr.u.imm, 12'h000};

	assign j_imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
			instr.j.imm11, instr.j.imm10_1, 1'b0};

endmodule : imm_gen

`default_nettype wire

// File: hw/execute/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
	import rv32i_types::*;
(
	input  wire logic           clk,
	input  wire logic           rst_n,
	input  wire logic           in_valid,

	input  wire alu_ops         aluop,
	input  wire branch_funct3_t cmpop,
	input  wire logic           alumux1_sel,
	input  wire logic [2:0]     alumux2_sel,
	input  wire logic           cmpmux_sel,
	input  wire logic [2:0]     memwbmux_sel,
	input  wire logic           load_regfile,
	input  wire logic           dec_mem_read,
	input  wire logic           dec_mem_write,
	input  wire logic           jump,
	input  wire logic           branch,
	input  wire logic [4:0]     rd,
	input  wire logic [31:0]    i_imm,
	input  wire logic [31:0]    s_imm,
	input  wire logic [31:0]    b_imm,
	input  wire logic [31:0]    u_imm,
	input  wire logic [31:0]    j_imm,
	input  wire logic [31:0]    rs1_data,
	input  wire logic [31:0]    rs2_data,
	input  wire logic [31:0]    mem_rdata,

	output logic                we,
	output logic [4:0]          waddr,
	output logic [31:0]         wdata,
	output logic                mem_read,
	output logic                mem_write,
	output logic [31:0]         mem_addr,
	output logic [31:0]         mem_wdata,
	output logic                retire_valid,
	output logic [31:0]         retire_pc,
	output logic [31:0]         retire_next_pc,
	output logic [4:0]          retire_rd,
	output logic                retire_we,
	output logic [31:0]         retire_wdata
);

	logic           ex_valid;
	logic           ex_load_regfile;
	logic           ex_mem_read;
	logic           ex_mem_write;
	logic           ex_jump;
	logic           ex_branch;
	alu_ops         ex_aluop;
	branch_funct3_t ex_cmpop;
	logic           ex_alumux1_sel;
	logic [2:0]     ex_alumux2_sel;
	logic           ex_cmpmux_sel;
	logic [2:0]     ex_memwbmux_sel;
	logic [4:0]     ex_rd;
	logic [31:0]    ex_i_imm;
	logic [31:0]    ex_s_imm;
	logic [31:0]    ex_b_imm;
	logic [31:0]    ex_u_imm;
	logic [31:0]    ex_j_imm;
	logic [31:0]    ex_rs1;
	logic [31:0]    ex_rs2;
	logic [31:0]    pc;

	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] alu_out;
	logic [31:0] cmp_b;
	logic        br_en;
	logic [31:0] pc_plus4;
	logic [31:0] next_pc;

	// control bits only go high for an accepted instruction
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid        <= 1'b0;
			ex_load_regfile <= 1'b0;
			ex_mem_read     <= 1'b0;
			ex_mem_write    <= 1'b0;
			ex_jump         <= 1'b0;
			ex_branch       <= 1'b0;
			pc              <= reset_pc;
		end else begin
			ex_valid        <= in_valid;
			ex_load_regfile <= in_valid & load_regfile;
			ex_mem_read     <= in_valid & dec_mem_read;
			ex_mem_write    <= in_valid & dec_mem_write;
			ex_jump         <= in_valid & jump;
			ex_branch       <= in_valid & branch;
			if (ex_valid)
				pc <= next_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			ex_aluop        <= aluop;
			ex_cmpop        <= cmpop;
			ex_alumux1_sel  <= alumux1_sel;
			ex_alumux2_sel  <= alumux2_sel;
			ex_cmpmux_sel   <= cmpmux_sel;
			ex_memwbmux_sel <= memwbmux_sel;
			ex_rd           <= rd;
			ex_i_imm        <= i_imm;
			ex_s_imm        <= s_imm;
			ex_b_imm        <= b_imm;
			ex_u_imm        <= u_imm;
			ex_j_imm        <= j_imm;
			ex_rs1          <= rs1_data;
			ex_rs2          <= rs2_data;
		end
	end

	assign alu_a = (ex_alumux1_sel == alumux1_pc) ? pc : ex_rs1;

	always_comb begin
		case (ex_alumux2_sel)
			alumux2_u:   alu_b = ex_u_imm;
			alumux2_b:   alu_b = ex_b_imm;
			alumux2_s:   alu_b = ex_s_imm;
			alumux2_rs2: alu_b = ex_rs2;
			alumux2_j:   alu_b = ex_j_imm;
			default:     alu_b = ex_i_imm;
		endcase
	end

	always_comb begin
		case (ex_aluop)
			alu_add: alu_out = alu_a + alu_b;
			alu_sll: alu_out = alu_a << alu_b[4:0];
			alu_sra: alu_out = $signed(alu_a) >>> alu_b[4:0];
			alu_sub: alu_out = alu_a - alu_b;
			alu_xor: alu_out = alu_a ^ alu_b;
			alu_srl: alu_out = alu_a >> alu_b[4:0];
			alu_or:  alu_out = alu_a | alu_b;
			default: alu_out = alu_a & alu_b;
		endcase
	end

	// SLT and SLTU reuse the branch comparator against rs2 or the I immediate
	assign cmp_b = (ex_cmpmux_sel == cmpmux_i) ? ex_i_imm : ex_rs2;

	always_comb begin
		case (ex_cmpop)
			beq:     br_en = ex_rs1 == cmp_b;
			bne:     br_en = ex_rs1 != cmp_b;
			blt:     br_en = $signed(ex_rs1) < $signed(cmp_b);
			bge:     br_en = $signed(ex_rs1) >= $signed(cmp_b);
			bltu:    br_en = ex_rs1 < cmp_b;
			bgeu:    br_en = ex_rs1 >= cmp_b;
			default: br_en = 1'b0;
		endcase
	end

	assign pc_plus4 = pc + 32'd4;

	always_comb begin
		if (ex_jump)
			next_pc = {alu_out[31:1], 1'b0};
		else if (ex_branch && br_en)
			next_pc = alu_out;
		else
			next_pc = pc_plus4;
	end

	always_comb begin
		case (ex_memwbmux_sel)
			memwbmux_cmp: wdata = {31'h0, br_en};
			memwbmux_u:   wdata = ex_u_imm;
			memwbmux_mem: wdata = mem_rdata;
			memwbmux_pc4: wdata = pc_plus4;
			default:      wdata = alu_out;
		endcase
	end

	assign we        = ex_load_regfile;
	assign waddr     = ex_rd;
	assign mem_read  = ex_mem_read;
	assign mem_write = ex_mem_write;
	assign mem_addr  = alu_out;
	assign mem_wdata = ex_rs2;

	assign retire_valid   = ex_valid;
	assign retire_pc      = pc;
	assign retire_next_pc = next_pc;
	assign retire_rd      = ex_rd;
	assign retire_we      = ex_load_regfile;
	assign retire_wdata   = wdata;

endmodule : execute_stage

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        we,
	input  wire logic [4:0]  waddr,
	input  wire logic [31:0] wdata,
	input  wire logic [4:0]  raddr1,
	input  wire logic [4:0]  raddr2,

	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [1:31];

	// a write landing this cycle is returned at once, so decode never sees stale data
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0)
			return 32'h0;
		else if (we && waddr == addr)
			return wdata;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= 32'h0;
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	always_comb begin
		rdata1 = read_port(raddr1);
		rdata2 = read_port(raddr2);
	end

endmodule : regfile

`default_nettype wire

// File: hw/rv32i_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_core
	import rv32i_types::*;
(
	input  wire logic         clk,
	input  wire logic         rst_n,
	input  wire logic         instr_valid,
	input  wire rv32i_instr_t instr,
	input  wire logic [31:0]  mem_rdata,

	output logic              mem_read,
	output logic              mem_write,
	output logic [31:0]       mem_addr,
	output logic [31:0]       mem_wdata,
	output logic              retire_valid,
	output logic [31:0]       retire_pc,
	output logic [31:0]       retire_next_pc,
	output logic [4:0]        retire_rd,
	output logic              retire_we,
	output logic [31:0]       retire_wdata
);

	alu_ops         aluop;
	branch_funct3_t cmpop;
	logic           alumux1_sel;
	logic [2:0]     alumux2_sel;
	logic           cmpmux_sel;
	logic [2:0]     memwbmux_sel;
	logic           load_regfile;
	logic           dec_mem_read;
	logic           dec_mem_write;
	logic           jump;
	logic           branch;
	logic [4:0]     rd;
	logic [4:0]     rs1;
	logic [4:0]     rs2;

	logic [31:0] i_imm;
	logic [31:0] s_imm;
	logic [31:0] b_imm;
	logic [31:0] u_imm;
	logic [31:0] j_imm;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;

	logic        wb_we;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;

	// register fields sit at the same bits in every format, so the R view serves all
	cpu_control control_i (
		.opcode       (rv32i_opcode'(instr.r.opcode)),
		.funct3       (instr.r.funct3),
		.funct7       (instr.r.funct7),
		.rd_in        (instr.r.rd),
		.rs1_in       (instr.r.rs1),
		.rs2_in       (instr.r.rs2),
		.aluop        (aluop),
		.cmpop        (cmpop),
		.alumux1_sel  (alumux1_sel),
		.alumux2_sel  (alumux2_sel),
		.cmpmux_sel   (cmpmux_sel),
		.memwbmux_sel (memwbmux_sel),
		.load_regfile (load_regfile),
		.mem_read     (dec_mem_read),
		.mem_write    (dec_mem_write),
		.jump         (jump),
		.branch       (branch),
		.rd           (rd),
		.rs1          (rs1),
		.rs2          (rs2)
	);

	imm_gen imm_gen_i (
		.instr (instr),
		.i_imm (i_imm),
		.s_imm (s_imm),
		.b_imm (b_imm),
		.u_imm (u_imm),
		.j_imm (j_imm)
	);

	regfile regfile_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.we     (wb_we),
		.waddr  (wb_addr),
		.wdata  (wb_data),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (rs1_data),
		.rdata2 (rs2_data)
	);

	execute_stage execute_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (instr_valid),
		.aluop          (aluop),
		.cmpop          (cmpop),
		.alumux1_sel    (alumux1_sel),
		.alumux2_sel    (alumux2_sel),
		.cmpmux_sel     (cmpmux_sel),
		.memwbmux_sel   (memwbmux_sel),
		.load_regfile   (load_regfile),
		.dec_mem_read   (dec_mem_read),
		.dec_mem_write  (dec_mem_write),
		.jump           (jump),
		.branch         (branch),
		.rd             (rd),
		.i_imm          (i_imm),
		.s_imm          (s_imm),
		.b_imm          (b_imm),
		.u_imm          (u_imm),
		.j_imm          (j_imm),
		.rs1_data       (rs1_data),
		.rs2_data       (rs2_data),
		.mem_rdata      (mem_rdata),
		.we             (wb_we),
		.waddr          (wb_addr),
		.wdata          (wb_data),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.retire_valid   (retire_valid),
		.retire_pc      (retire_pc),
		.retire_next_pc (retire_next_pc),
		.retire_rd      (retire_rd),
		.retire_we      (retire_we),
		.retire_wdata   (retire_wdata)
	);

endmodule : rv32i_core

`default_nettype wire

// File: rv32i_core.f
common/rv32i_types.sv
hw/decode/cpu_control.sv
hw/decode/imm_gen.sv
hw/regfile.sv
hw/execute/execute_stage.sv
hw/rv32i_core.sv
verification/clock_gen.sv
verification/rv32i_core_tb.sv

// File: verification/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset is released on a rising edge after 16 cycles
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule : clock_gen

`default_nettype wire

// File: verification/rv32i_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_core_tb
	import rv32i_types::*;
();

	// the tests issue under 150 instructions, so this leaves ample margin
	localparam int cycle_limit = 2000;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] mem_rdata;
	logic        mem_read;
	logic        mem_write;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic        retire_valid;
	logic [31:0] retire_pc;
	logic [31:0] retire_next_pc;
	logic [4:0]  retire_rd;
	logic        retire_we;
	logic [31:0] retire_wdata;

	logic [31:0] mem [0:255];
	logic [31:0] ref_mem [0:255];
	logic [31:0] ref_regs [0:31];
	logic [31:0] ref_pc;
	logic        st_en;
	logic [7:0]  st_idx;
	logic [31:0] st_data;

	// expected retires in program order
	// ctl holds {rd, we, mem_read, mem_write}
	logic [31:0] exp_pc [$];
	logic [31:0] exp_npc [$];
	logic [31:0] exp_wdata [$];
	logic [31:0] exp_maddr [$];
	logic [31:0] exp_mwdata [$];
	logic [7:0]  exp_ctl [$];

	integer seed;
	int     mismatches;
	int     tests_passed;
	int     tests_failed;
	int     cycles;

	clock_gen clock_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	rv32i_core dut_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.mem_rdata      (mem_rdata),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.retire_valid   (retire_valid),
		.retire_pc      (retire_pc),
		.retire_next_pc (retire_next_pc),
		.retire_rd      (retire_rd),
		.retire_we      (retire_we),
		.retire_wdata   (retire_wdata)
	);

	// scratch memory answers at once and takes stores at the edge ending the cycle
	assign mem_rdata = mem[mem_addr[9:2]];

	always @(negedge clk) begin
		st_en   <= mem_write;
		st_idx  <= mem_addr[9:2];
		st_data <= mem_wdata;
	end

	always @(posedge clk) begin
		if (st_en === 1'b1)
			mem[st_idx] <= st_data;
	end

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			mismatches++;
			$display("[FAIL] %s: got %08h, expected %08h", name, actual, expected);
		end
	endtask

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_br};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] x,
			input logic [31:0] y, input logic alt);
		logic signed [31:0] sx;
		sx = x;
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'h0, $signed(x) < $signed(y)};
			3'd3: return {31'h0, x < y};
			3'd4: return x ^ y;
			3'd5: begin
				if (alt)
					return sx >>> y[4:0];
				return x >> y[4:0];
			end
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	// the architectural model predicts the retire of one instruction and commits it
	task automatic model_step(input logic [31:0] w);
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] addr;
		logic [31:0] wd;
		logic [31:0] npc;
		logic        we;
		logic        rd_en;
		logic        wr_en;
		logic        taken;
		rd    = w[11:7];
		f3    = w[14:12];
		a     = ref_regs[w[19:15]];
		b     = ref_regs[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		addr  = 32'h0;
		wd    = 32'h0;
		npc   = ref_pc + 32'd4;
		we    = 1'b0;
		rd_en = 1'b0;
		wr_en = 1'b0;
		case (w[6:0])
			op_lui: begin
				we = 1'b1;
				wd = {w[31:12], 12'h0};
			end
			op_auipc: begin
				we = 1'b1;
				wd = ref_pc + {w[31:12], 12'h0};
			end
			op_jal: begin
				we  = 1'b1;
				wd  = ref_pc + 32'd4;
				npc = ref_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			op_jalr: begin
				we  = 1'b1;
				wd  = ref_pc + 32'd4;
				npc = (a + imm_i) & 32'hffff_fffe;
			end
			op_br: begin
				case (f3)
					3'd0: taken = a == b;
					3'd1: taken = a != b;
					3'd4: taken = $signed(a) < $signed(b);
					3'd5: taken = $signed(a) >= $signed(b);
					3'd6: taken = a < b;
					default: taken = a >= b;
				endcase
				if (taken)
					npc = ref_pc + imm_b;
			end
			op_load: begin
				we    = 1'b1;
				rd_en = 1'b1;
				addr  = a + imm_i;
				wd    = ref_mem[addr[9:2]];
			end
			op_store: begin
				wr_en = 1'b1;
				addr  = a + imm_s;
				ref_mem[addr[9:2]] = b;
			end
			op_imm: begin
				we = 1'b1;
				wd = alu_ref(f3, a, imm_i, f3 == 3'd5 && w[30]);
			end
			default: begin
				we = 1'b1;
				wd = alu_ref(f3, a, b, w[30]);
			end
		endcase
		exp_pc.push_back(ref_pc);
		exp_npc.push_back(npc);
		exp_wdata.push_back(wd);
		exp_maddr.push_back(addr);
		exp_mwdata.push_back(b);
		exp_ctl.push_back({we ? rd : 5'd0, we, rd_en, wr_en});
		if (we && rd != 5'd0)
			ref_regs[rd] = wd;
		ref_pc = npc;
	endtask

	always @(negedge clk) begin : monitor
		logic [7:0] ctl;
		if (rst_n) begin
			if (retire_valid && exp_pc.size() == 0) begin
				mismatches++;
				$display("a retire was reported with no instruction outstanding");
			end else if (retire_valid) begin
				ctl = exp_ctl.pop_front();
				check("retire_pc", retire_pc, exp_pc.pop_front());
				check("retire_next_pc", retire_next_pc, exp_npc.pop_front());
				check("retire_rd", retire_rd, ctl[7:3]);
				check("retire_we", retire_we, ctl[2]);
				check("mem_read", mem_read, ctl[1]);
				check("mem_write", mem_write, ctl[0]);
				if (ctl[2])
					check("retire_wdata", retire_wdata, exp_wdata[0]);
				if (ctl[1] || ctl[0])
					check("mem_addr", mem_addr, exp_maddr[0]);
				if (ctl[0])
					check("mem_wdata", mem_wdata, exp_mwdata[0]);
				void'(exp_wdata.pop_front());
				void'(exp_maddr.pop_front());
				void'(exp_mwdata.pop_front());
			end else begin
				check("mem_read", mem_read, 1'b0);
				check("mem_write", mem_write, 1'b0);
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the DUT stopped retiring", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	task automatic issue(input logic [31:0] w);
		model_step(w);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= w;
	endtask

	task automatic drain();
		@(posedge clk);
		instr_valid <= 1'b0;
		while (exp_pc.size() != 0)
			@(negedge clk);
	endtask

	task automatic report_test(input string name, input int start);
		drain();
		if (mismatches == start) begin
			tests_passed++;
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d mismatches", name, mismatches - start);
		end
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] hi;
		hi = value + 32'h800;
		issue(u_type(hi[31:12], rd, op_lui));
		issue(i_type(value[11:0], rd, 3'd0, rd, op_imm));
	endtask

	task automatic after_reset();
		int start;
		start = mismatches;
		@(negedge clk);
		check("retire_valid", retire_valid, 1'b0);
		check("mem_read", mem_read, 1'b0);
		check("mem_write", mem_write, 1'b0);
		issue(u_type(20'h12345, 5'd1, op_lui));
		report_test("reset", start);
	endtask

	task automatic immediate_ops();
		int          start;
		logic [31:0] r;
		start = mismatches;
		r = $random(seed);
		load_const(5'd1, r | 32'h8000_0000);
		r = $random(seed);
		load_const(5'd2, r);
		for (int f = 0; f < 8; f++) begin
			r = $random(seed);
			if (f != 1 && f != 5)
				issue(i_type(r[11:0], (f & 1) ? 5'd1 : 5'd2, f[2:0], 5'd3 + f[4:0], op_imm));
		end
		r = $random(seed);
		issue(i_type({7'h00, r[4:0]}, 5'd1, 3'd1, 5'd11, op_imm));
		issue(i_type({7'h00, r[9:5]}, 5'd1, 3'd5, 5'd12, op_imm));
		issue(i_type({7'h20, r[14:10]}, 5'd1, 3'd5, 5'd13, op_imm));
		// x0 must stay zero after being written
		issue(i_type(12'h123, 5'd1, 3'd0, 5'd0, op_imm));
		issue(i_type(12'h000, 5'd0, 3'd0, 5'd14, op_imm));
		report_test("register-immediate", start);
	endtask

	task automatic dependent_reg_ops();
		localparam logic [39:0] op_list = 40'h76d5432180;
		int          start;
		logic [3:0]  code;
		logic [31:0] r;
		start = mismatches;
		r = $random(seed);
		load_const(5'd20, r);
		r = $random(seed);
		load_const(5'd21, r | 32'h8000_0000);
		issue(r_type(7'h00, 5'd21, 5'd20, 3'd0, 5'd22));
		// every operation reads the result of the one just before it
		for (int k = 0; k < 10; k++) begin
			code = op_list[k*4 +: 4];
			issue(r_type(code[3] ? 7'h20 : 7'h00, (k & 1) ? 5'd21 : 5'd20, 5'd22,
					code[2:0], 5'd22));
		end
		report_test("register-register", start);
	endtask

	task automatic pc_relative_ops();
		int start;
		start = mismatches;
		issue(u_type(20'h00010, 5'd13, op_auipc));
		issue(j_type(21'd16, 5'd1));
		issue(i_type(12'h000, 5'd1, 3'd0, 5'd2, op_imm));
		issue(j_type(21'h1ffff4, 5'd3));
		issue(u_type(20'h00000, 5'd13, op_auipc));
		issue(i_type(12'd5, 5'd13, 3'd0, 5'd5, op_jalr));
		issue(i_type(12'h000, 5'd5, 3'd0, 5'd6, op_imm));
		issue(i_type(12'hffd, 5'd13, 3'd0, 5'd7, op_jalr));
		issue(i_type(12'h004, 5'd7, 3'd0, 5'd8, op_imm));
		report_test("pc-relative", start);
	endtask

	task automatic branch_conditions();
		localparam logic [39:0] pairs = {5'd16, 5'd14, 5'd15, 5'd15, 5'd15, 5'd14, 5'd14, 5'd15};
		int          start;
		logic [9:0]  pair;
		logic [12:0] off;
		start = mismatches;
		issue(i_type(12'hfff, 5'd0, 3'd0, 5'd14, op_imm));
		issue(i_type(12'h001, 5'd0, 3'd0, 5'd15, op_imm));
		issue(u_type(20'h80000, 5'd16, op_lui));
		for (int p = 0; p < 4; p++) begin
			pair = pairs[p*10 +: 10];
			for (int f = 0; f < 8; f++) begin
				off = ((p + f) & 1) ? 13'h1ff8 : 13'h000c;
				if (f != 2 && f != 3)
					issue(b_type(off, pair[4:0], pair[9:5], f[2:0]));
			end
		end
		report_test("branches", start);
	endtask

	task automatic word_loads_stores();
		int          start;
		logic [31:0] r;
		logic [31:0] o;
		logic [11:0] off;
		start = mismatches;
		issue(i_type(12'h100, 5'd0, 3'd0, 5'd16, op_imm));
		for (int i = 0; i < 4; i++) begin
			r = $random(seed);
			o = $random(seed);
			off = {{7{o[3]}}, o[2:0], 2'b00};
			load_const(5'd17, r);
			issue(s_type(off, 5'd17, 5'd16));
			issue(i_type(off, 5'd16, 3'd2, 5'd18, op_load));
		end
		issue(i_type(12'h040, 5'd0, 3'd2, 5'd19, op_load));
		report_test("loads and stores", start);
	endtask

	initial begin
		seed         = 32'h67f4927d;
		instr_valid  = 1'b0;
		instr        = 32'h0;
		st_en        = 1'b0;
		mismatches   = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycles       = 0;
		ref_pc       = reset_pc;
		for (int i = 0; i < 256; i++) begin
			mem[i]     = 32'h9e37_79b9 * (i + 1);
			ref_mem[i] = mem[i];
		end
		for (int i = 0; i < 32; i++)
			ref_regs[i] = 32'h0;
		while (rst_n !== 1'b1)
			@(posedge clk);
		after_reset();
		immediate_ops();
		dependent_reg_ops();
		pc_relative_ops();
		branch_conditions();
		word_loads_stores();
		$display("tests passed %0d, tests failed %0d, mismatches %0d",
				tests_passed, tests_failed, mismatches);
		if (mismatches == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule : rv32i_core_tb

`default_nettype wire
